// ==== hw/ecc_config.svh ====
`ifndef ECC_CONFIG_SVH
`define ECC_CONFIG_SVH

// field element width, prime must be odd and below 2**ECC_WIDTH
`define ECC_WIDTH 16

// scalar width, top bit taken as set
`define ECC_KEY_BITS 8

`endif

// ==== hw/ecc_pkg.sv ====
`include "ecc_config.svh"

package ecc_pkg;

    typedef enum logic [1:0] {
        GF_ADD = 2'b00,
        GF_SUB = 2'b01,
        GF_MUL = 2'b10,
        GF_DIV = 2'b11                   // lhs * inverse(rhs)
    } gf_op_e;

    typedef logic [`ECC_WIDTH-1:0] gf_elem_t;

    typedef struct packed {
        gf_op_e   op;
        gf_elem_t lhs;
        gf_elem_t rhs;
    } gf_req_t;

    typedef struct packed {
        gf_elem_t x;
        gf_elem_t y;
    } point_t;

    typedef struct packed {
        gf_elem_t a;
        gf_elem_t p;
    } curve_t;

    typedef enum logic [1:0] {
        CMD_LOAD,
        CMD_DOUBLE,
        CMD_ADD
    } point_cmd_e;

endpackage

// ==== hw/gf_mod_mul.sv ====
`timescale 1ns/1ps
`include "ecc_config.svh"

module gf_mod_mul
    import ecc_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_start,
    input  gf_elem_t i_a,
    input  gf_elem_t i_b,
    input  gf_elem_t i_prime,
    output logic     o_done,
    output gf_elem_t o_product
);

    localparam int CNT_W = $clog2(`ECC_WIDTH) + 1;

    gf_elem_t         acc;
    gf_elem_t         a_q;
    gf_elem_t         b_sh;
    logic [CNT_W-1:0] cnt;
    logic             busy;

    // acc = 2*acc + bit*a, reduced after each half
    function automatic gf_elem_t mul_step(input gf_elem_t acc_in, input logic bit_in,
                                          input gf_elem_t a_in, input gf_elem_t p_in);
        logic [`ECC_WIDTH:0] t;
        t = {acc_in, 1'b0};
        if (t >= {1'b0, p_in})
            t = t - {1'b0, p_in};
        if (bit_in)
            t = t + {1'b0, a_in};
        if (t >= {1'b0, p_in})
            t = t - {1'b0, p_in};
        return t[`ECC_WIDTH-1:0];
    endfunction

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            busy   <= 1'b0;
            cnt    <= '0;
            o_done <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (i_start)
            begin
                busy <= 1'b1;
                cnt  <= CNT_W'(`ECC_WIDTH - 1);  // first bit done at start
            end
            else if (busy)
            begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1))
                begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_start)
        begin
            acc  <= mul_step('0, i_b[`ECC_WIDTH-1], i_a, i_prime);
            a_q  <= i_a;
            b_sh <= i_b << 1;
        end
        else if (busy)
        begin
            acc  <= mul_step(acc, b_sh[`ECC_WIDTH-1], a_q, i_prime);
            b_sh <= b_sh << 1;
        end
    end

    assign o_product = acc;

endmodule

// ==== hw/gf_mod_inv.sv ====
`timescale 1ns/1ps
`include "ecc_config.svh"

module gf_mod_inv
    import ecc_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_start,
    input  gf_elem_t i_value,
    input  gf_elem_t i_prime,
    output logic     o_done,
    output gf_elem_t o_inverse
);

    gf_elem_t u;
    gf_elem_t v;
    gf_elem_t x1;            // x1 * value == u mod p
    gf_elem_t x2;            // x2 * value == v mod p
    logic     busy;
    logic     finish;

    function automatic gf_elem_t half_mod(input gf_elem_t x, input gf_elem_t p);
        logic [`ECC_WIDTH:0] t;
        t = x[0] ? ({1'b0, x} + {1'b0, p}) : {1'b0, x};
        return t[`ECC_WIDTH:1];
    endfunction

    function automatic gf_elem_t sub_mod(input gf_elem_t x, input gf_elem_t y,
                                         input gf_elem_t p);
        return (x >= y) ? (x - y) : (x - y + p);
    endfunction

    assign finish = (u == gf_elem_t'(1)) || (v == gf_elem_t'(1));

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            busy   <= 1'b0;
            o_done <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (i_start)
            begin
                busy   <= (i_value != '0);
                o_done <= (i_value == '0);   // inverse of 0 taken as 0
            end
            else if (busy && finish)
            begin
                busy   <= 1'b0;
                o_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_start)
        begin
            u         <= i_value;
            v         <= i_prime;
            x1        <= gf_elem_t'(1);
            x2        <= '0;
            o_inverse <= '0;
        end
        else if (busy)
        begin
            if (u == gf_elem_t'(1))
                o_inverse <= x1;
            else if (v == gf_elem_t'(1))
                o_inverse <= x2;
            else if (!u[0])
            begin
                u  <= u >> 1;
                x1 <= half_mod(x1, i_prime);
            end
            else if (!v[0])
            begin
                v  <= v >> 1;
                x2 <= half_mod(x2, i_prime);
            end
            else if (u >= v)
            begin
                u  <= (u - v) >> 1;      // odd minus odd, halve at once
                x1 <= half_mod(sub_mod(x1, x2, i_prime), i_prime);
            end
            else
            begin
                v  <= (v - u) >> 1;
                x2 <= half_mod(sub_mod(x2, x1, i_prime), i_prime);
            end
        end
    end

    a_no_restart: assert property (@(posedge i_clk) disable iff (i_reset)
        i_start |-> !busy)
        else $error("inverse restarted while running");

endmodule

// ==== hw/gf_arith_unit.sv ====
`timescale 1ns/1ps
`include "ecc_config.svh"

module gf_arith_unit
    import ecc_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_req_valid,
    input  gf_req_t  i_req,
    input  gf_elem_t i_prime,
    output logic     o_done,
    output gf_elem_t o_result
);

    gf_req_t             req_q;
    gf_elem_t            alu_res;
    gf_elem_t            res_q;
    logic [`ECC_WIDTH:0] sum;
    logic                pending;
    logic                alu_done;
    logic                mul_start;
    logic                inv_start;
    logic                mul_done;
    logic                inv_done;
    gf_elem_t            mul_product;
    gf_elem_t            inv_value;

    always_comb
    begin
        sum = {1'b0, i_req.lhs} + {1'b0, i_req.rhs};
        if (i_req.op == GF_SUB)
        begin
            alu_res = i_req.lhs - i_req.rhs;
            if (i_req.lhs < i_req.rhs)
                alu_res = alu_res + i_prime;
        end
        else if (sum >= {1'b0, i_prime})
            alu_res = gf_elem_t'(sum - {1'b0, i_prime});
        else
            alu_res = sum[`ECC_WIDTH-1:0];
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            pending   <= 1'b0;
            alu_done  <= 1'b0;
            mul_start <= 1'b0;
            inv_start <= 1'b0;
        end
        else
        begin
            alu_done  <= 1'b0;
            mul_start <= 1'b0;
            inv_start <= 1'b0;
            if (i_req_valid)
            begin
                pending   <= 1'b1;
                alu_done  <= (i_req.op == GF_ADD) || (i_req.op == GF_SUB);
                mul_start <= (i_req.op == GF_MUL);
                inv_start <= (i_req.op == GF_DIV);
            end
            else if (o_done)
                pending <= 1'b0;
            else if (pending && inv_done)
                mul_start <= 1'b1;       // second half of divide
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_req_valid)
        begin
            req_q <= i_req;
            res_q <= alu_res;
        end
    end

    gf_mod_mul u_mul (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_start   (mul_start),
        .i_a       (req_q.lhs),
        .i_b       ((req_q.op == GF_DIV) ? inv_value : req_q.rhs),
        .i_prime   (i_prime),
        .o_done    (mul_done),
        .o_product (mul_product)
    );

    gf_mod_inv u_inv (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_start   (inv_start),
        .i_value   (req_q.rhs),
        .i_prime   (i_prime),
        .o_done    (inv_done),
        .o_inverse (inv_value)
    );

    assign o_done   = alu_done | mul_done;
    assign o_result = (req_q.op inside {GF_ADD, GF_SUB}) ? res_q : mul_product;

    a_single_req: assert property (@(posedge i_clk) disable iff (i_reset)
        i_req_valid |-> !pending)
        else $error("field request while one is pending");

endmodule

// ==== hw/point_op_seq.sv ====
`timescale 1ns/1ps
`include "ecc_config.svh"

module point_op_seq
    import ecc_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_cmd_valid,
    input  point_cmd_e i_cmd,
    input  curve_t     i_curve,
    input  point_t     i_base,
    input  logic       i_gf_done,
    input  gf_elem_t   i_gf_result,
    output logic       o_done,
    output point_t     o_point,
    output logic       o_gf_req_valid,
    output gf_req_t    o_gf_req
);

    typedef enum logic [2:0] {SRC_X, SRC_Y, SRC_R1, SRC_R2, SRC_A, SRC_BX, SRC_BY} src_e;
    typedef enum logic [1:0] {DST_X, DST_Y, DST_R1, DST_R2} dst_e;

    typedef struct packed {
        gf_op_e op;
        src_e   lhs;
        src_e   rhs;
        dst_e   dst;
    } uop_t;

    localparam logic [4:0] PC_DOUBLE   = 5'd0;
    localparam logic [4:0] PC_ADD      = 5'd12;
    localparam logic [4:0] PC_ADD_TAIL = 5'd16;
    localparam logic [4:0] PC_REJOIN   = 5'd8;
    localparam logic [4:0] PC_LAST     = 5'd11;

    point_t     q;
    gf_elem_t   r1;
    gf_elem_t   r2;
    logic [4:0] pc;
    logic       busy;
    uop_t       uop;

    function automatic uop_t ucode(input logic [4:0] idx);
        case (idx)
            5'd0:    ucode = '{GF_MUL, SRC_X,  SRC_X,  DST_R1};   // x^2
            5'd1:    ucode = '{GF_ADD, SRC_R1, SRC_R1, DST_R2};
            5'd2:    ucode = '{GF_ADD, SRC_R1, SRC_R2, DST_R1};   // 3x^2
            5'd3:    ucode = '{GF_ADD, SRC_R1, SRC_A,  DST_R1};
            5'd4:    ucode = '{GF_ADD, SRC_Y,  SRC_Y,  DST_R2};   // 2y
            5'd5:    ucode = '{GF_DIV, SRC_R1, SRC_R2, DST_R1};   // lambda
            5'd6:    ucode = '{GF_MUL, SRC_R1, SRC_R1, DST_R2};
            5'd7:    ucode = '{GF_SUB, SRC_R2, SRC_X,  DST_R2};
            5'd8:    ucode = '{GF_SUB, SRC_R2, SRC_X,  DST_R2};   // x'
            5'd9:    ucode = '{GF_SUB, SRC_X,  SRC_R2, DST_X};
            5'd10:   ucode = '{GF_MUL, SRC_R1, SRC_X,  DST_X};
            5'd12:   ucode = '{GF_SUB, SRC_BY, SRC_Y,  DST_R1};   // add entry
            5'd13:   ucode = '{GF_SUB, SRC_BX, SRC_X,  DST_R2};
            5'd14:   ucode = '{GF_DIV, SRC_R1, SRC_R2, DST_R1};
            5'd15:   ucode = '{GF_MUL, SRC_R1, SRC_R1, DST_R2};
            5'd16:   ucode = '{GF_SUB, SRC_R2, SRC_BX, DST_R2};
            default: ucode = '{GF_SUB, SRC_X,  SRC_Y,  DST_Y};    // pc 11, y'
        endcase
    endfunction

    function automatic gf_elem_t operand(input src_e sel);
        case (sel)
            SRC_X:   operand = q.x;
            SRC_Y:   operand = q.y;
            SRC_R1:  operand = r1;
            SRC_R2:  operand = r2;
            SRC_A:   operand = i_curve.a;
            SRC_BX:  operand = i_base.x;
            default: operand = i_base.y;
        endcase
    endfunction

    assign uop = ucode(pc);

    always_comb
    begin
        o_gf_req.op  = uop.op;
        o_gf_req.lhs = operand(uop.lhs);
        o_gf_req.rhs = operand(uop.rhs);
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            busy           <= 1'b0;
            pc             <= PC_DOUBLE;
            o_done         <= 1'b0;
            o_gf_req_valid <= 1'b0;
        end
        else
        begin
            o_done         <= 1'b0;
            o_gf_req_valid <= 1'b0;
            if (i_cmd_valid)
            begin
                if (i_cmd == CMD_LOAD)
                    o_done <= 1'b1;
                else
                begin
                    busy           <= 1'b1;
                    o_gf_req_valid <= 1'b1;
                    pc             <= (i_cmd == CMD_ADD) ? PC_ADD : PC_DOUBLE;
                end
            end
            else if (busy && i_gf_done)
            begin
                if (pc == PC_LAST)
                begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
                else
                begin
                    pc             <= (pc == PC_ADD_TAIL) ? PC_REJOIN : pc + 1'b1;
                    o_gf_req_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_cmd_valid && i_cmd == CMD_LOAD)
            q <= i_base;
        else if (busy && i_gf_done)
        begin
            case (uop.dst)
                DST_X:  q.x <= i_gf_result;
                DST_Y:
                begin
                    q.y <= i_gf_result;
                    q.x <= r2;           // x' held in r2 until y' is done
                end
                DST_R1: r1 <= i_gf_result;
                default: r2 <= i_gf_result;
            endcase
        end
    end

    assign o_point = q;

    a_cmd_idle: assert property (@(posedge i_clk) disable iff (i_reset)
        i_cmd_valid |-> !busy)
        else $error("point command while busy");

endmodule

// ==== hw/key_scan_ctrl.sv ====
`timescale 1ns/1ps
`include "ecc_config.svh"

module key_scan_ctrl
    import ecc_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_start,
    input  logic [`ECC_KEY_BITS-1:0] i_key,
    input  logic                     i_cmd_done,
    output logic                     o_cmd_valid,
    output point_cmd_e               o_cmd,
    output logic                     o_busy,
    output logic                     o_done
);

    localparam int CNT_W = $clog2(`ECC_KEY_BITS);

    logic [`ECC_KEY_BITS-1:0] key_sh;      // msb is the bit under scan
    logic [CNT_W-1:0]         bits_left;
    logic [CNT_W-1:0]         bits_after;

    // load consumes no key bit
    assign bits_after = (o_cmd == CMD_LOAD) ? bits_left : bits_left - 1'b1;

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            o_cmd_valid <= 1'b0;
            o_cmd       <= CMD_LOAD;
            o_busy      <= 1'b0;
            o_done      <= 1'b0;
            bits_left   <= '0;
        end
        else
        begin
            o_cmd_valid <= 1'b0;
            o_done      <= 1'b0;
            if (i_start && !o_busy)
            begin
                o_busy      <= 1'b1;
                o_cmd       <= CMD_LOAD;
                o_cmd_valid <= 1'b1;
                bits_left   <= CNT_W'(`ECC_KEY_BITS - 1);
            end
            else if (o_busy && i_cmd_done)
            begin
                if (o_cmd == CMD_DOUBLE && key_sh[`ECC_KEY_BITS-1])
                begin
                    o_cmd       <= CMD_ADD;
                    o_cmd_valid <= 1'b1;
                end
                else
                begin
                    bits_left <= bits_after;
                    if (bits_after == '0)
                    begin
                        o_busy <= 1'b0;
                        o_done <= 1'b1;
                    end
                    else
                    begin
                        o_cmd       <= CMD_DOUBLE;
                        o_cmd_valid <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_start && !o_busy)
            key_sh <= i_key << 1;    // top bit implied by load
        else if (o_busy && i_cmd_done && o_cmd != CMD_LOAD
                 && !(o_cmd == CMD_DOUBLE && key_sh[`ECC_KEY_BITS-1]))
            key_sh <= key_sh << 1;
    end

endmodule

// ==== hw/ecc_point_mul.sv ====
`timescale 1ns/1ps
`include "ecc_config.svh"

module ecc_point_mul
    import ecc_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_start,
    input  curve_t                   i_curve,
    input  point_t                   i_base,
    input  logic [`ECC_KEY_BITS-1:0] i_key,
    output point_t                   o_result,
    output logic                     o_done,
    output logic                     o_busy
);

    logic       cmd_valid;
    point_cmd_e cmd;
    logic       cmd_done;
    logic       gf_req_valid;
    gf_req_t    gf_req;
    logic       gf_done;
    gf_elem_t   gf_result;

    key_scan_ctrl u_key_scan (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_key       (i_key),
        .i_cmd_done  (cmd_done),
        .o_cmd_valid (cmd_valid),
        .o_cmd       (cmd),
        .o_busy      (o_busy),
        .o_done      (o_done)
    );

    point_op_seq u_point_seq (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_cmd_valid    (cmd_valid),
        .i_cmd          (cmd),
        .i_curve        (i_curve),
        .i_base         (i_base),
        .i_gf_done      (gf_done),
        .i_gf_result    (gf_result),
        .o_done         (cmd_done),
        .o_point        (o_result),
        .o_gf_req_valid (gf_req_valid),
        .o_gf_req       (gf_req)
    );

    gf_arith_unit u_gf_unit (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req_valid (gf_req_valid),
        .i_req       (gf_req),
        .i_prime     (i_curve.p),
        .o_done      (gf_done),
        .o_result    (gf_result)
    );

endmodule

// ==== verif/ecc_ref_model.svh ====
`ifndef ECC_REF_MODEL_SVH
`define ECC_REF_MODEL_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic longint mod_add(input longint x, input longint y, input longint p);
    return (x + y) % p;
endfunction

function automatic longint mod_sub(input longint x, input longint y, input longint p);
    return (x - y + p) % p;
endfunction

function automatic longint mod_mul(input longint x, input longint y, input longint p);
    return (x * y) % p;
endfunction

// fermat inverse, 0 maps to 0
function automatic longint mod_inv(input longint x, input longint p);
    longint r;
    longint b;
    longint e;
    r = 1;
    b = x % p;
    e = p - 2;
    while (e > 0)
    begin
        if (e % 2 == 1)
            r = mod_mul(r, b, p);
        b = mod_mul(b, b, p);
        e = e / 2;
    end
    return r;
endfunction

// left-to-right double-and-add, top key bit taken as set
function automatic point_t ref_scalar_mul(input logic [`ECC_KEY_BITS-1:0] key,
                                          input point_t base, input longint a,
                                          input longint p, output bit degenerate);
    longint qx;
    longint qy;
    longint bx;
    longint by;
    longint lam;
    longint nx;
    point_t r;
    degenerate = 1'b0;
    bx = base.x;
    by = base.y;
    qx = bx;
    qy = by;
    for (int i = `ECC_KEY_BITS - 2; i >= 0; i--)
    begin
        if (qy == 0)
            degenerate = 1'b1;                  // tangent is vertical
        lam = mod_add(mod_mul(3, mod_mul(qx, qx, p), p), a, p);
        lam = mod_mul(lam, mod_inv(mod_add(qy, qy, p), p), p);
        nx  = mod_sub(mod_mul(lam, lam, p), mod_add(qx, qx, p), p);
        qy  = mod_sub(mod_mul(lam, mod_sub(qx, nx, p), p), qy, p);
        qx  = nx;
        if (key[i])
        begin
            if (qx == bx)
                degenerate = 1'b1;              // chord undefined
            lam = mod_mul(mod_sub(by, qy, p), mod_inv(mod_sub(bx, qx, p), p), p);
            nx  = mod_sub(mod_sub(mod_mul(lam, lam, p), qx, p), bx, p);
            qy  = mod_sub(mod_mul(lam, mod_sub(qx, nx, p), p), qy, p);
            qx  = nx;
        end
    end
    r.x = gf_elem_t'(qx);
    r.y = gf_elem_t'(qy);
    return r;
endfunction

`endif

// ==== verif/tb_ecc_point_mul.sv ====
`timescale 1ns/1ps
`include "ecc_config.svh"

module tb_ecc_point_mul
    import ecc_pkg::*;
();

    localparam gf_elem_t PRIME      = gf_elem_t'(65519);
    localparam gf_elem_t CURVE_A    = gf_elem_t'(3);
    localparam int       RUNS       = 20;
    localparam int       MAX_CYCLES = 100000;   // 20 runs x 14 ops x 350 cycles, rounded up

    logic                     i_clk;
    logic                     i_reset;
    logic                     i_start;
    curve_t                   i_curve;
    point_t                   i_base;
    logic [`ECC_KEY_BITS-1:0] i_key;
    point_t                   o_result;
    logic                     o_done;
    logic                     o_busy;

    point_t      expected;
    string       test_name;
    logic        started;
    int          outstanding;                   // accepted starts not yet done
    int          cycles;
    logic [31:0] rng_state;

    `include "ecc_ref_model.svh"

    ecc_point_mul DUT (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_start  (i_start),
        .i_curve  (i_curve),
        .i_base   (i_base),
        .i_key    (i_key),
        .o_result (o_result),
        .o_done   (o_done),
        .o_busy   (o_busy)
    );

    always #2 i_clk = ~i_clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    always @(posedge i_clk)
    begin
        if (!i_reset)
        begin
            if (i_start && !o_busy)
                started <= 1'b1;
            outstanding <= outstanding + int'(i_start && !o_busy) - int'(o_done);
        end
    end

    always @(posedge i_clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
            abort_run("timeout, the multiplier did not finish within the cycle limit");
    end

    a_idle_before_start: assert property (@(posedge i_clk) disable iff (i_reset)
        !started |-> !o_busy && !o_done)
        else abort_run("o_busy or o_done went high before any start");

    a_busy_after_start: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_start && !o_busy) |=> o_busy)
        else abort_run("o_busy did not rise the cycle after an accepted start");

    a_busy_until_done: assert property (@(posedge i_clk) disable iff (i_reset)
        o_busy |=> o_busy || o_done)
        else abort_run("o_busy fell without an o_done pulse");

    a_busy_from_start: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(o_busy) |-> $past(i_start))
        else abort_run("o_busy rose without a start");

    a_done_ends_busy: assert property (@(posedge i_clk) disable iff (i_reset)
        o_done |-> !o_busy && $past(o_busy))
        else abort_run("o_done did not coincide with the fall of o_busy");

    a_done_single: assert property (@(posedge i_clk) disable iff (i_reset)
        o_done |=> !o_done)
        else abort_run("o_done lasted more than one cycle");

    a_done_per_start: assert property (@(posedge i_clk) disable iff (i_reset)
        o_done |-> outstanding == 1)
        else abort_run($sformatf("** Error [%s] pending starts at o_done expected 1 actual %0d",
                                 test_name, $sampled(outstanding)));

    a_result: assert property (@(posedge i_clk) disable iff (i_reset)
        o_done |-> o_result == expected)
        else abort_run($sformatf("** Error [%s] o_result expected %h/%h actual %h/%h",
                                 test_name, expected.x, expected.y,
                                 $sampled(o_result.x), $sampled(o_result.y)));

    // redraws until the reference sees no degenerate step
    task automatic draw_case(input logic [`ECC_KEY_BITS-1:0] fixed_key, input bit random_key,
                             output logic [`ECC_KEY_BITS-1:0] key, output point_t base);
        bit     degenerate;
        point_t unused;
        degenerate = 1'b1;
        while (degenerate)
        begin
            rng_state = xorshift32(rng_state);
            base.x    = gf_elem_t'(rng_state % PRIME);
            rng_state = xorshift32(rng_state);
            base.y    = gf_elem_t'(rng_state % PRIME);
            rng_state = xorshift32(rng_state);
            key       = random_key ? rng_state[`ECC_KEY_BITS-1:0] : fixed_key;
            key[`ECC_KEY_BITS-1] = 1'b1;
            unused    = ref_scalar_mul(key, base, CURVE_A, PRIME, degenerate);
        end
    endtask

    task automatic run_mul(input string name, input logic [`ECC_KEY_BITS-1:0] key,
                           input point_t base, input bit poke_busy);
        bit degenerate;
        test_name = name;
        expected  = ref_scalar_mul(key, base, CURVE_A, PRIME, degenerate);
        i_key     = key;
        i_base    = base;
        i_start   = 1'b1;
        next_cycle();
        i_start = 1'b0;
        next_cycle();
        if (poke_busy)
        begin
            repeat (20) next_cycle();
            i_key   = ~key;                     // a restart would change the result
            i_start = 1'b1;
            next_cycle();
            i_start = 1'b0;
            i_key   = key;
        end
        while (!o_done)
            next_cycle();
        next_cycle();                           // result check samples this edge
    endtask

    initial
    begin
        logic [`ECC_KEY_BITS-1:0] key;
        point_t                   base;
        i_clk       = 1'b0;
        i_reset     = 1'b1;
        i_start     = 1'b0;
        i_key       = '0;
        i_base      = '0;
        i_curve.a   = CURVE_A;
        i_curve.p   = PRIME;
        started     = 1'b0;
        outstanding = 0;
        cycles      = 0;
        rng_state   = 32'd89;
        test_name   = "reset";
        expected    = '0;
        repeat (5) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        repeat (10) next_cycle();               // idle after reset

        draw_case('0, 1'b0, key, base);
        run_mul("double_only", key, base, 1'b0);
        for (int n = 0; n < RUNS - 2; n++)
        begin
            draw_case('0, 1'b1, key, base);
            run_mul("random_mul", key, base, n == 5);
        end
        draw_case('1, 1'b0, key, base);
        run_mul("add_every_bit", key, base, 1'b0);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== ecc_point_mul.f ====
+incdir+hw
+incdir+verif
hw/ecc_pkg.sv
hw/gf_mod_mul.sv
hw/gf_mod_inv.sv
hw/gf_arith_unit.sv
hw/point_op_seq.sv
hw/key_scan_ctrl.sv
hw/ecc_point_mul.sv
verif/tb_ecc_point_mul.sv
